/* tests/lullaby_stim.txt */
# name start stop cycles beat
# One command cycle with start/stop, then idle cycles, then beat (binary) is checked
# Out of reset the tune plays from step 0
after_reset_step0 0 0 0 1000
after_reset_step1 0 0 0 1111
after_reset_step2 0 0 0 1000
after_reset_step3 0 0 0 0100
step4 0 0 0 0001
step5 0 0 0 0010
step6 0 0 0 0001
step7 0 0 0 0001
# Rests keep the last pattern
rest_step8 0 0 0 0001
rest_step9 0 0 0 0001
rest_to_step11 0 0 1 0001
step12 0 0 0 0001
step13 0 0 0 1111
run_to_step19 0 0 5 1111
rest_to_step23 0 0 3 1111
step24 0 0 0 0100
step25 0 0 0 0010
run_to_step29 0 0 3 0100
rest_to_step35 0 0 5 1111
step36 0 0 0 1000
run_to_step40 0 0 3 1000
step41 0 0 0 1111
run_to_step79 0 0 37 0100
rest_to_step83 0 0 3 0100
step84 0 0 0 1000
step85 0 0 0 1111
run_to_step87 0 0 1 0100
step88 0 0 0 0001
rest_to_step94 0 0 5 0001
step95 0 0 0 0010
run_to_step100 0 0 4 1000
run_to_step103 0 0 2 0001
step104 0 0 0 0001
rest_to_step107 0 0 2 0001
step108 0 0 0 0010
run_to_step113 0 0 4 1000
run_to_step115 0 0 1 1111
run_to_step121 0 0 5 0001
# Step 122 is step 0 again
wrap_step0 0 0 0 1000
wrap_step1 0 0 0 1111
full_loop_back_to_step1 0 0 121 1111
loop_step2 0 0 0 1000
# Start while playing changes nothing
start_in_play_step3 1 0 0 0100
step4_after_start 0 0 0 0001
start_in_play_step5 1 0 0 0010
step6_after_start 0 0 0 0001
run_to_step23 0 0 16 1111
# Stop freezes the pattern of the step it samples
stop_at_step24 0 1 0 0100
idle_hold 0 0 20 0100
stop_in_idle 0 1 0 0100
idle_hold_long 0 0 60 0100
stop_in_idle_wait 0 1 5 0100
# Start from idle plays step 0 one edge later
start_from_idle 1 0 0 0100
restart_step0 0 0 0 1000
restart_step1 0 0 0 1111
restart_step2 0 0 0 1000
restart_step3 0 0 0 0100
restart_to_step12 0 0 8 0001
stop_at_step13 0 1 0 1111
start_and_run_to_step2 1 0 3 1000
stop_at_step3 0 1 0 0100
idle_after_step3 0 0 10 0100
start_and_run_to_step9 1 0 10 0001
stop_on_rest_step10 0 1 0 0001
idle_after_rest 0 0 15 0001
start_and_run_to_step120 1 0 121 0001
end_step121 0 0 0 0001
end_wrap_step0 0 0 0 1000

/* lullaby.f */
+incdir+source
source/lullaby_pkg.sv
source/lullaby_player.sv
source/lullaby_score.sv
source/lullaby.sv
tests/lullaby_tb.sv

/* run_lullaby.sh */
#!/bin/sh
# Builds the lullaby testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

build_dir=build
sim_name=lullaby_sim
log_file="$build_dir/lullaby_sim.log"

verilator --binary --timing --assert \
        -f lullaby.f \
        --top-module lullaby_tb \
        -Mdir "$build_dir" \
        -o "$sim_name"
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

"./$build_dir/$sim_name" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

# The log decides the result
if grep -q "TEST FAILED" "$log_file"; then
        exit 1
fi
if ! grep -q "TEST OK" "$log_file"; then
        echo "Simulation ended without a result line"
        exit 1
fi
exit 0

/* tests/lullaby_tb.sv */
module lullaby_tb;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int reset_cycles    = 4;
        localparam int max_line_cycles = 1000;     // Longest wait one stim line may ask for
        localparam int max_stim_lines  = 1000;
        localparam int max_gap_cycles  = 7;
        localparam int line_chars      = 160;
        localparam int name_chars      = 40;
        localparam string stim_path    = "tests/lullaby_stim.txt";

        logic               clock;
        logic               reset;
        logic               start;
        logic               stop;
        lullaby_pkg::beat_t beat;

        int test_count;
        int pass_count;
        int fail_count;
        bit aborted;                               // Set on a timeout or a bad stim file

        lullaby DUT
        (
                .clock (clock),
                .reset (reset),
                .start (start),
                .stop  (stop),
                .beat  (beat)
        );

        // ==================================================
        // Clock

        initial
        begin
                clock = 1'b0;
                forever
                        #2 clock = ~clock;
        end

        // ==================================================
        // Helpers

        // Each cycle ends on a falling edge, where inputs change and beat is stable
        task automatic run_cycles(input int count, input string what);
                int i;
                i = 0;
                while (i < count && !aborted)
                begin
                        if (i >= max_line_cycles)
                        begin
                                $display("Timeout while %0s: still waiting after %0d cycles",
                                         what, max_line_cycles);
                                aborted = 1'b1;
                        end
                        else
                        begin
                                @(posedge clock);
                                @(negedge clock);
                                i++;
                        end
                end
        endtask

        task automatic check_beat(input string name, input lullaby_pkg::beat_t expected,
                                  inout bit test_ok);
                assert (beat === expected)
                else
                begin
                        $display("CHECK FAILED %0s: expected %b, actual %b",
                                 name, expected, beat);
                        test_ok = 1'b0;
                end
        endtask

        // Leftmost non-null character of a token read with $sscanf
        function automatic logic [7:0] first_char(input logic [8*name_chars-1:0] word);
                logic [7:0] c;
                c = 8'h00;
                for (int i = name_chars - 1; i >= 0; i--)
                begin
                        if (c == 8'h00)
                                c = word[i*8 +: 8];
                end
                return c;
        endfunction

        // One command cycle, then idle cycles, then the beat check
        task automatic run_test(input string name, input bit start_value, input bit stop_value,
                                input int cycles, input lullaby_pkg::beat_t expected);
                bit test_ok;
                int gap;
                test_ok = 1'b1;
                gap     = 0;
                start   = start_value;
                stop    = stop_value;
                run_cycles(1, name);
                start = 1'b0;
                stop  = 1'b0;
                run_cycles(cycles, name);
                if (!aborted)
                begin
                        check_beat(name, expected, test_ok);

                        // A lone stop always leaves the player idle
                        if (stop_value && !start_value)
                        begin
                                gap = $urandom_range(max_gap_cycles, 0);
                                run_cycles(gap, name);
                                if (!aborted)
                                        check_beat({name, " after idle gap"}, expected,
                                                   test_ok);
                        end
                end
                if (!aborted)
                begin
                        test_count++;
                        if (test_ok)
                        begin
                                pass_count++;
                                $display("test %0s passed", name);
                        end
                        else
                        begin
                                fail_count++;
                                $display("test %0s failed", name);
                        end
                end
        endtask

        // ==================================================
        // Stimulus

        initial
        begin
                int                        fd;
                int                        fields;
                int                        line_count;
                logic [8*line_chars-1:0]   line_bits;
                logic [8*name_chars-1:0]   name_bits;
                string                     name_text;
                int                        start_value;
                int                        stop_value;
                int                        cycles;
                logic [3:0]                expected;

                reset       = 1'b0;
                start       = 1'b0;
                stop        = 1'b0;
                test_count  = 0;
                pass_count  = 0;
                fail_count  = 0;
                aborted     = 1'b0;
                line_count  = 0;
                start_value = 0;
                stop_value  = 0;
                cycles      = 0;
                expected    = '0;
                void'($urandom(32'he3e8_bae6));

                fd = $fopen(stim_path, "r");
                if (fd == 0)
                begin
                        $display("Cannot open the stimulus file %0s", stim_path);
                        aborted = 1'b1;
                end

                run_cycles(reset_cycles, "holding reset");
                reset = 1'b1;                      // Released on a falling edge

                while (!aborted && !$feof(fd))
                begin
                        if (line_count >= max_stim_lines)
                        begin
                                $display("Timeout while reading stimulus: more than %0d lines",
                                         max_stim_lines);
                                aborted = 1'b1;
                        end
                        else
                        begin
                                line_count++;
                                line_bits = '0;
                                name_bits = '0;
                                void'($fgets(line_bits, fd));
                                fields = $sscanf(line_bits, "%s %d %d %d %b", name_bits,
                                                 start_value, stop_value, cycles, expected);
                                if (fields < 1 || first_char(name_bits) == "#")
                                        ;              // Blank or comment line
                                else if (fields != 5)
                                begin
                                        $display("Stimulus line %0d does not have five fields",
                                                 line_count);
                                        aborted = 1'b1;
                                end
                                else
                                begin
                                        name_text = $sformatf("%0s", name_bits);
                                        run_test(name_text, (start_value != 0),
                                                 (stop_value != 0), cycles, expected);
                                end
                        end
                end
                if (fd != 0)
                        $fclose(fd);

                // ==================================================
                // Summary

                $display("Tests run: %0d, passed: %0d, failed: %0d",
                         test_count, pass_count, fail_count);
                if (fail_count == 0 && test_count > 0 && !aborted)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

/* source/lullaby.sv */
module lullaby
(
        input  logic               clock,
        input  logic               reset,
        input  logic               start,
        input  logic               stop,
        output lullaby_pkg::beat_t beat
);

        lullaby_pkg::step_t step;
        logic               playing;   // High while the tune runs

        lullaby_player
        #(
                .SONG_LENGTH (lullaby_pkg::song_length)
        )
        player
        (
                .clock   (clock),
                .reset   (reset),
                .start   (start),
                .stop    (stop),
                .step    (step),
                .playing (playing)
        );

        lullaby_score score
        (
                .clock   (clock),
                .reset   (reset),
                .step    (step),
                .playing (playing),
                .beat    (beat)
        );

endmodule

/* source/lullaby_score.sv */
module lullaby_score
(
        input  logic               clock,
        input  logic               reset,
        input  lullaby_pkg::step_t step,
        input  logic               playing,
        output lullaby_pkg::beat_t beat
);

`include "lullaby_song.svh"

        lullaby_pkg::beat_t code;

        // ==================================================
        // Table lookup

        assign code = song_code(step);

        // ==================================================
        // Beat register

        // Rests and idle cycles leave the last pattern in place
        always_ff @(posedge clock or negedge reset)
        begin
                if (!reset)
                        beat <= '0;
                else if (playing && (code != lullaby_pkg::beat_rest))
                        beat <= code;
        end

endmodule

/* source/lullaby_player.sv */
module lullaby_player
#(
        parameter int SONG_LENGTH = 122
)
(
        input  logic               clock,
        input  logic               reset,
        input  logic               start,
        input  logic               stop,
        output lullaby_pkg::step_t step,
        output logic               playing
);

        localparam lullaby_pkg::step_t last_step = lullaby_pkg::step_t'(SONG_LENGTH - 1);

        lullaby_pkg::player_state_t state;

        // ==================================================
        // Idle/play control and step counter

        always_ff @(posedge clock or negedge reset)
        begin
                if (!reset)
                begin
                        state <= lullaby_pkg::player_play;     // Plays straight out of reset
                        step  <= '0;
                end
                else
                begin
                        case (state)
                                lullaby_pkg::player_play:
                                begin
                                        if (stop)
                                        begin
                                                state <= lullaby_pkg::player_idle;
                                                step  <= '0;
                                        end
                                        else if (step == last_step)
                                                step <= '0;    // Loop to the top of the tune
                                        else
                                                step <= step + 1'b1;
                                end

                                lullaby_pkg::player_idle:
                                begin
                                        if (start)
                                        begin
                                                state <= lullaby_pkg::player_play;
                                                step  <= '0;
                                        end
                                end

                                default:
                                        state <= lullaby_pkg::player_idle;
                        endcase
                end
        end

        assign playing = (state == lullaby_pkg::player_play);

endmodule

/* source/lullaby_pkg.sv */
package lullaby_pkg;

        // ==================================================
        // Types

        typedef logic [3:0] beat_t;     // One bit per percussion lane
        typedef logic [6:0] step_t;     // Position in the tune

        typedef enum logic
        {
                player_idle,
                player_play
        } player_state_t;

        // Number of steps before the tune loops
        localparam int song_length = 122;

        // ==================================================
        // Beat codes

        // An all-zero code is a rest, so the previous beat stays on the output
        localparam beat_t beat_rest   = 4'b0000;

        localparam beat_t beat_lane_0 = 4'b0001;
        localparam beat_t beat_lane_1 = 4'b0010;
        localparam beat_t beat_lane_2 = 4'b0100;
        localparam beat_t beat_lane_3 = 4'b1000;

        localparam beat_t beat_all    = 4'b1111;    // All lanes together

endpackage

/* source/lullaby_song.svh */
`ifndef LULLABY_SONG_SVH
`define LULLABY_SONG_SVH

        // ==================================================
        // Score table with one entry per step

        function automatic lullaby_pkg::beat_t song_code(input lullaby_pkg::step_t index);
                case (index)
                        7'd0:   song_code = lullaby_pkg::beat_lane_3;
                        7'd1:   song_code = lullaby_pkg::beat_all;
                        7'd2:   song_code = lullaby_pkg::beat_lane_3;
                        7'd3:   song_code = lullaby_pkg::beat_lane_2;
                        7'd4:   song_code = lullaby_pkg::beat_lane_0;
                        7'd5:   song_code = lullaby_pkg::beat_lane_1;
                        7'd6:   song_code = lullaby_pkg::beat_lane_0;
                        7'd7:   song_code = lullaby_pkg::beat_lane_0;
                        7'd8:   song_code = lullaby_pkg::beat_rest;
                        7'd9:   song_code = lullaby_pkg::beat_rest;
                        7'd10:  song_code = lullaby_pkg::beat_rest;
                        7'd11:  song_code = lullaby_pkg::beat_rest;
                        7'd12:  song_code = lullaby_pkg::beat_lane_0;
                        7'd13:  song_code = lullaby_pkg::beat_all;
                        7'd14:  song_code = lullaby_pkg::beat_all;
                        7'd15:  song_code = lullaby_pkg::beat_all;
                        7'd16:  song_code = lullaby_pkg::beat_all;
                        7'd17:  song_code = lullaby_pkg::beat_all;
                        7'd18:  song_code = lullaby_pkg::beat_all;
                        7'd19:  song_code = lullaby_pkg::beat_all;
                        7'd20:  song_code = lullaby_pkg::beat_rest;
                        7'd21:  song_code = lullaby_pkg::beat_rest;
                        7'd22:  song_code = lullaby_pkg::beat_rest;
                        7'd23:  song_code = lullaby_pkg::beat_rest;
                        7'd24:  song_code = lullaby_pkg::beat_lane_2;
                        7'd25:  song_code = lullaby_pkg::beat_lane_1;
                        7'd26:  song_code = lullaby_pkg::beat_lane_2;
                        7'd27:  song_code = lullaby_pkg::beat_lane_2;
                        7'd28:  song_code = lullaby_pkg::beat_lane_1;
                        7'd29:  song_code = lullaby_pkg::beat_lane_2;
                        7'd30:  song_code = lullaby_pkg::beat_all;
                        7'd31:  song_code = lullaby_pkg::beat_all;
                        7'd32:  song_code = lullaby_pkg::beat_rest;
                        7'd33:  song_code = lullaby_pkg::beat_rest;
                        7'd34:  song_code = lullaby_pkg::beat_rest;
                        7'd35:  song_code = lullaby_pkg::beat_rest;
                        7'd36:  song_code = lullaby_pkg::beat_lane_3;
                        7'd37:  song_code = lullaby_pkg::beat_lane_3;
                        7'd38:  song_code = lullaby_pkg::beat_lane_3;
                        7'd39:  song_code = lullaby_pkg::beat_all;
                        7'd40:  song_code = lullaby_pkg::beat_lane_3;
                        7'd41:  song_code = lullaby_pkg::beat_all;
                        7'd42:  song_code = lullaby_pkg::beat_all;
                        7'd43:  song_code = lullaby_pkg::beat_all;
                        7'd44:  song_code = lullaby_pkg::beat_rest;
                        7'd45:  song_code = lullaby_pkg::beat_rest;
                        7'd46:  song_code = lullaby_pkg::beat_rest;
                        7'd47:  song_code = lullaby_pkg::beat_rest;
                        7'd48:  song_code = lullaby_pkg::beat_all;     // Long full-kit run
                        7'd49:  song_code = lullaby_pkg::beat_all;
                        7'd50:  song_code = lullaby_pkg::beat_all;
                        7'd51:  song_code = lullaby_pkg::beat_all;
                        7'd52:  song_code = lullaby_pkg::beat_all;
                        7'd53:  song_code = lullaby_pkg::beat_all;
                        7'd54:  song_code = lullaby_pkg::beat_all;
                        7'd55:  song_code = lullaby_pkg::beat_all;
                        7'd56:  song_code = lullaby_pkg::beat_rest;
                        7'd57:  song_code = lullaby_pkg::beat_rest;
                        7'd58:  song_code = lullaby_pkg::beat_rest;
                        7'd59:  song_code = lullaby_pkg::beat_rest;
                        7'd60:  song_code = lullaby_pkg::beat_all;
                        7'd61:  song_code = lullaby_pkg::beat_all;
                        7'd62:  song_code = lullaby_pkg::beat_all;
                        7'd63:  song_code = lullaby_pkg::beat_all;
                        7'd64:  song_code = lullaby_pkg::beat_all;
                        7'd65:  song_code = lullaby_pkg::beat_all;
                        7'd66:  song_code = lullaby_pkg::beat_all;
                        7'd67:  song_code = lullaby_pkg::beat_all;
                        7'd68:  song_code = lullaby_pkg::beat_rest;
                        7'd69:  song_code = lullaby_pkg::beat_rest;
                        7'd70:  song_code = lullaby_pkg::beat_rest;
                        7'd71:  song_code = lullaby_pkg::beat_rest;
                        7'd72:  song_code = lullaby_pkg::beat_all;
                        7'd73:  song_code = lullaby_pkg::beat_all;
                        7'd74:  song_code = lullaby_pkg::beat_all;
                        7'd75:  song_code = lullaby_pkg::beat_lane_3;
                        7'd76:  song_code = lullaby_pkg::beat_all;
                        7'd77:  song_code = lullaby_pkg::beat_all;
                        7'd78:  song_code = lullaby_pkg::beat_lane_2;
                        7'd79:  song_code = lullaby_pkg::beat_lane_2;
                        7'd80:  song_code = lullaby_pkg::beat_rest;
                        7'd81:  song_code = lullaby_pkg::beat_rest;
                        7'd82:  song_code = lullaby_pkg::beat_rest;
                        7'd83:  song_code = lullaby_pkg::beat_rest;
                        7'd84:  song_code = lullaby_pkg::beat_lane_3;  // Opening figure again
                        7'd85:  song_code = lullaby_pkg::beat_all;
                        7'd86:  song_code = lullaby_pkg::beat_lane_3;
                        7'd87:  song_code = lullaby_pkg::beat_lane_2;
                        7'd88:  song_code = lullaby_pkg::beat_lane_0;
                        7'd89:  song_code = lullaby_pkg::beat_lane_2;
                        7'd90:  song_code = lullaby_pkg::beat_lane_0;
                        7'd91:  song_code = lullaby_pkg::beat_lane_0;
                        7'd92:  song_code = lullaby_pkg::beat_rest;
                        7'd93:  song_code = lullaby_pkg::beat_rest;
                        7'd94:  song_code = lullaby_pkg::beat_rest;
                        7'd95:  song_code = lullaby_pkg::beat_lane_1;
                        7'd96:  song_code = lullaby_pkg::beat_all;
                        7'd97:  song_code = lullaby_pkg::beat_all;
                        7'd98:  song_code = lullaby_pkg::beat_all;
                        7'd99:  song_code = lullaby_pkg::beat_all;
                        7'd100: song_code = lullaby_pkg::beat_lane_3;
                        7'd101: song_code = lullaby_pkg::beat_all;
                        7'd102: song_code = lullaby_pkg::beat_all;
                        7'd103: song_code = lullaby_pkg::beat_lane_0;
                        7'd104: song_code = lullaby_pkg::beat_lane_0;
                        7'd105: song_code = lullaby_pkg::beat_rest;
                        7'd106: song_code = lullaby_pkg::beat_rest;
                        7'd107: song_code = lullaby_pkg::beat_rest;
                        7'd108: song_code = lullaby_pkg::beat_lane_1;
                        7'd109: song_code = lullaby_pkg::beat_all;
                        7'd110: song_code = lullaby_pkg::beat_all;
                        7'd111: song_code = lullaby_pkg::beat_all;
                        7'd112: song_code = lullaby_pkg::beat_all;
                        7'd113: song_code = lullaby_pkg::beat_lane_3;
                        7'd114: song_code = lullaby_pkg::beat_all;
                        7'd115: song_code = lullaby_pkg::beat_all;
                        7'd116: song_code = lullaby_pkg::beat_lane_0;  // Closing roll on lane 0
                        7'd117: song_code = lullaby_pkg::beat_lane_0;
                        7'd118: song_code = lullaby_pkg::beat_lane_0;
                        7'd119: song_code = lullaby_pkg::beat_lane_0;
                        7'd120: song_code = lullaby_pkg::beat_lane_0;
                        7'd121: song_code = lullaby_pkg::beat_lane_0;
                        default: song_code = lullaby_pkg::beat_rest;   // Past the end of the tune
                endcase
        endfunction

`endif
